// File: source/spdif_pkg.sv
// **********************************************************
// S/PDIF shared definitions: frame geometry, preamble
// patterns and the transmitter state type
// **********************************************************

package spdif_pkg;

  // **********************************************************
  // Frame geometry

  // Data slots after the preamble
  // 24 audio bits, then validity, user, status, parity
  localparam int SUBFRAME_BITS = 28;

  // Clocks per biphase cell at 11.2896 MHz and 44.1 kHz
  localparam int CELL_CLKS = 4;

  // Preamble spans four cells
  localparam int PREAMBLE_CLKS = 16;

  // Frames in one channel-status block
  localparam int BLOCK_FRAMES = 192;

  // **********************************************************
  // Preamble patterns

  // Patterns for a line that was last low
  // Bit 0 goes out first, one bit per spdif clock
  // Each pattern ends at the level it started from
  // Left channel, not block start
  localparam logic [PREAMBLE_CLKS-1:0] PREAMBLE_X = 16'b0011_0000_0011_1111;
  // Right channel
  localparam logic [PREAMBLE_CLKS-1:0] PREAMBLE_Y = 16'b0000_1100_0011_1111;
  // Left channel, first frame of a block
  localparam logic [PREAMBLE_CLKS-1:0] PREAMBLE_Z = 16'b0000_0011_0011_1111;

  // **********************************************************
  // Transmitter FSM

  typedef enum logic [1:0] {
    IDLE,
    PREAMBLE,
    DATA
  } tx_state_t;

endpackage

// File: source/spdif_strobe_cdc.sv
`timescale 1ns/100ps
// **********************************************************
// Strobe synchronizer: one source-clock strobe becomes one
// destination-clock pulse through a toggle flag
// **********************************************************

module spdif_strobe_cdc (
  input  logic src_clk_i,
  input  logic dst_clk_i,
  input  logic strobe_i,
  output logic strobe_o
);

  // Source edge detector, toggle flag and destination synchronizer start cleared
  logic       strobe_q = 1'b0;
  logic       toggle   = 1'b0;
  logic [2:0] sync     = 3'b000;

  // Source domain
  // Only the rising edge counts, so a held level crosses as one pulse
  always_ff @(posedge src_clk_i)
  begin
    strobe_q <= strobe_i;
    if (strobe_i && !strobe_q)
    begin
      toggle <= ~toggle;
    end
  end

  // Destination domain
  // sync[0] may go metastable while sync[2] still holds the old flag value
  always_ff @(posedge dst_clk_i)
  begin
    sync <= {sync[1:0], toggle};
  end

  // One pulse per flag change
  assign strobe_o = sync[2] ^ sync[1];

endmodule

// File: source/spdif_subframe_builder.sv
`timescale 1ns/100ps
// **********************************************************
// Subframe builder: latches the sample, left-justifies it to
// 24 bits and forms the 28-bit slot with even parity
// **********************************************************

module spdif_subframe_builder #(
  parameter int DATA_WIDTH = 24
) (
  input  logic                                spdif_clk_i,
  input  logic                                srst,
  input  logic                                sample_stb_i,
  input  logic [DATA_WIDTH-1:0]               sample_i,
  input  logic                                load_i,
  output logic                                valid_o,
  output logic [spdif_pkg::SUBFRAME_BITS-1:0] subframe_o
);

  // Audio field, the three fixed flags and parity fill the slot
  localparam int AUDIO_BITS = spdif_pkg::SUBFRAME_BITS - 4;

  // Validity, user and channel status, all zero (0 = valid)
  localparam logic [2:0] VUC_BITS = 3'b000;

  logic [AUDIO_BITS-1:0] audio;
  logic                  parity;

  // Sample register
  // 16-bit samples get a zero low byte
  always_ff @(posedge spdif_clk_i)
  begin
    if (sample_stb_i)
    begin
      audio <= AUDIO_BITS'(sample_i) << (AUDIO_BITS - DATA_WIDTH);
    end
  end

  // Set by the first sample, cleared only by reset
  always_ff @(posedge spdif_clk_i)
  begin
    if (srst)
    begin
      valid_o <= 1'b0;
    end
    else if (sample_stb_i)
    begin
      valid_o <= 1'b1;
    end
  end

  // Flag bits are zero, so audio alone sets the parity
  assign parity = ^audio;

  // Copied once per frame, held for both subframes
  // LSB of audio is the first data slot on the line
  always_ff @(posedge spdif_clk_i)
  begin
    if (load_i)
    begin
      subframe_o <= {parity, VUC_BITS, audio};
    end
  end

endmodule

// File: source/spdif_transmitter.sv
`timescale 1ns/100ps
// **********************************************************
// S/PDIF transmitter: preamble and data FSM, block counting
// and biphase-mark line coding
// **********************************************************

module spdif_transmitter (
  input  logic                                spdif_clk_i,
  input  logic                                srst,
  input  logic                                valid_i,
  input  logic [spdif_pkg::SUBFRAME_BITS-1:0] subframe_i,
  output logic                                load_o,
  output logic                                spdif_o
);

  // Counter widths
  localparam int CNT_W   = $clog2(spdif_pkg::PREAMBLE_CLKS);
  localparam int BIT_W   = $clog2(spdif_pkg::SUBFRAME_BITS);
  localparam int FRAME_W = $clog2(spdif_pkg::BLOCK_FRAMES);

  // Channel flag values
  localparam logic LEFT  = 1'b0;
  localparam logic RIGHT = 1'b1;

  spdif_pkg::tx_state_t state;

  // Clock within a cell or preamble
  logic [CNT_W-1:0]   cnt;
  // Data slot within the subframe
  logic [BIT_W-1:0]   bit_cnt;
  // Frame within the channel-status block
  logic [FRAME_W-1:0] frame_cnt;
  logic               channel;
  // Line level at the end of the last cell or preamble
  logic               last_level;

  logic [spdif_pkg::PREAMBLE_CLKS-1:0] preamble;
  logic                                preamble_end;
  logic                                cell_end;
  logic                                subframe_end;
  logic                                line_level;

  // **********************************************************
  // Boundaries

  assign preamble_end = (state == spdif_pkg::PREAMBLE) &&
                        (cnt == CNT_W'(spdif_pkg::PREAMBLE_CLKS - 1));
  assign cell_end     = (state == spdif_pkg::DATA) &&
                        (cnt == CNT_W'(spdif_pkg::CELL_CLKS - 1));
  assign subframe_end = cell_end && (bit_cnt == BIT_W'(spdif_pkg::SUBFRAME_BITS - 1));

  // **********************************************************
  // FSM and counters

  // Once started, subframes run back to back, 128 clocks each
  always_ff @(posedge spdif_clk_i)
  begin
    if (srst)
    begin
      state   <= spdif_pkg::IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      channel <= LEFT;
    end
    else
    begin
      case (state)
        spdif_pkg::IDLE:
        begin
          cnt <= '0;
          // First sample is in, start with a left preamble
          if (valid_i)
          begin
            state <= spdif_pkg::PREAMBLE;
          end
        end
        spdif_pkg::PREAMBLE:
        begin
          if (preamble_end)
          begin
            state   <= spdif_pkg::DATA;
            cnt     <= '0;
            bit_cnt <= '0;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        spdif_pkg::DATA:
        begin
          if (subframe_end)
          begin
            state   <= spdif_pkg::PREAMBLE;
            cnt     <= '0;
            channel <= ~channel;
          end
          else if (cell_end)
          begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        default:
        begin
          state <= spdif_pkg::IDLE;
        end
      endcase
    end
  end

  // Advances after each right subframe, frame 0 carries Z
  always_ff @(posedge spdif_clk_i)
  begin
    if (srst)
    begin
      frame_cnt <= '0;
    end
    else if (subframe_end && (channel == RIGHT))
    begin
      if (frame_cnt == FRAME_W'(spdif_pkg::BLOCK_FRAMES - 1))
      begin
        frame_cnt <= '0;
      end
      else
      begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // Sample is copied one clock before every left preamble
  assign load_o = ((state == spdif_pkg::IDLE) && valid_i) ||
                  (subframe_end && (channel == RIGHT));

  // **********************************************************
  // Line coding

  always_comb
  begin
    if (channel == RIGHT)
    begin
      preamble = spdif_pkg::PREAMBLE_Y;
    end
    else if (frame_cnt == '0)
    begin
      preamble = spdif_pkg::PREAMBLE_Z;
    end
    else
    begin
      preamble = spdif_pkg::PREAMBLE_X;
    end
  end

  // Biphase mark: flip at every cell start, flip again mid-cell for a one
  // Preamble patterns are stored for a low line, so invert after a high one
  always_comb
  begin
    case (state)
      spdif_pkg::PREAMBLE:
      begin
        line_level = preamble[cnt] ^ last_level;
      end
      spdif_pkg::DATA:
      begin
        if (cnt < CNT_W'(spdif_pkg::CELL_CLKS / 2))
        begin
          line_level = ~last_level;
        end
        else
        begin
          line_level = last_level ^ ~subframe_i[bit_cnt];
        end
      end
      default:
      begin
        line_level = 1'b0;
      end
    endcase
  end

  // Level carried into the next cell, line idles low
  always_ff @(posedge spdif_clk_i)
  begin
    if (srst || (state == spdif_pkg::IDLE))
    begin
      last_level <= 1'b0;
    end
    else if (preamble_end || cell_end)
    begin
      last_level <= line_level;
    end
  end

  // Registered line output, one clock behind the FSM
  always_ff @(posedge spdif_clk_i)
  begin
    if (srst)
    begin
      spdif_o <= 1'b0;
    end
    else
    begin
      spdif_o <= line_level;
    end
  end

endmodule

// File: source/spdif_tx_top.sv
`timescale 1ns/100ps
// **********************************************************
// Mono S/PDIF transmitter top: clock crossing, subframe
// builder and line transmitter
// **********************************************************

module spdif_tx_top #(
  parameter int DATA_WIDTH = 24
) (
  input  logic                  sys_clk_i,
  input  logic                  srst_i,
  input  logic                  spdif_clk_i,
  input  logic [DATA_WIDTH-1:0] sample_i,
  input  logic                  sample_valid_i,
  output logic                  spdif_o
);

  // spdif-domain reset, a one-cycle pulse
  logic                                srst;
  logic                                sample_stb;
  logic                                valid;
  logic                                load;
  logic [spdif_pkg::SUBFRAME_BITS-1:0] subframe;

  // Reset crossing
  spdif_strobe_cdc srst_cdc (
    .src_clk_i (sys_clk_i),
    .dst_clk_i (spdif_clk_i),
    .strobe_i  (srst_i),
    .strobe_o  (srst)
  );

  // Sample strobe crossing, sample_i stays stable meanwhile
  spdif_strobe_cdc sample_cdc (
    .src_clk_i (sys_clk_i),
    .dst_clk_i (spdif_clk_i),
    .strobe_i  (sample_valid_i),
    .strobe_o  (sample_stb)
  );

  spdif_subframe_builder #(
    .DATA_WIDTH (DATA_WIDTH)
  ) builder (
    .spdif_clk_i  (spdif_clk_i),
    .srst         (srst),
    .sample_stb_i (sample_stb),
    .sample_i     (sample_i),
    .load_i       (load),
    .valid_o      (valid),
    .subframe_o   (subframe)
  );

  spdif_transmitter transmitter (
    .spdif_clk_i (spdif_clk_i),
    .srst        (srst),
    .valid_i     (valid),
    .subframe_i  (subframe),
    .load_o      (load),
    .spdif_o     (spdif_o)
  );

endmodule

// File: verif/spdif_monitor.sv
`timescale 1ns/100ps
// **********************************************************
// S/PDIF line monitor: decodes preambles and biphase-mark
// cells and checks them against the expected sample
// **********************************************************

module spdif_monitor (
  input  logic        spdif_clk_i,
  input  logic        armed_i,
  input  logic        spdif_i,
  input  logic [23:0] expected_sample_i,
  input  logic        exp_changed_i,
  output int          errors_o,
  output int          subframes_o
);

  localparam int AUDIO_BITS = spdif_pkg::SUBFRAME_BITS - 4;

  int errors       = 0;
  int subframes    = 0;
  int z_count      = 0;
  int changes      = 0;
  int changes_seen = 0;
  // Subframes that may still carry the previous sample
  int grace        = 0;
  int frame_idx    = 0;
  int pos          = 0;
  int bit_idx      = 0;

  logic [AUDIO_BITS-1:0]               cur_exp     = '0;
  logic [AUDIO_BITS-1:0]               prev_exp    = '0;
  logic [AUDIO_BITS-1:0]               left_audio  = '0;
  // Hunting window, newest sample at the top, bit 0 is the level before it
  logic [16:0]                         win         = '0;
  logic [15:0]                         pre_buf     = '0;
  logic [3:0]                          cell_buf    = '0;
  logic [spdif_pkg::SUBFRAME_BITS-1:0] bits        = '0;
  logic                                last_level  = 1'b0;
  logic                                started     = 1'b0;
  logic                                locked      = 1'b0;
  logic                                in_data     = 1'b0;
  logic                                ever_locked = 1'b0;
  logic                                block_known = 1'b0;
  logic                                cur_right   = 1'b1;
  logic                                idle_fault  = 1'b0;

  assign errors_o    = errors;
  assign subframes_o = subframes;

  // Pattern letter for a 16-clock window, 0 when it matches none
  function automatic byte classify_preamble(input logic [15:0] p, input logic ref_level);
    logic [15:0] rel;
    rel = p ^ {16{ref_level}};
    if (rel === spdif_pkg::PREAMBLE_X)
      return "X";
    if (rel === spdif_pkg::PREAMBLE_Y)
      return "Y";
    if (rel === spdif_pkg::PREAMBLE_Z)
      return "Z";
    return 0;
  endfunction

  task automatic report_fault(input string what);
    errors++;
    $display("%s", what);
  endtask

  // Back to hunting after a line coding fault
  task automatic lose_lock(input string what, input logic s);
    report_fault($sformatf("%s at %0t", what, $time));
    locked      = 1'b0;
    in_data     = 1'b0;
    block_known = 1'b0;
    win         = {17{s}};
  endtask

  // **********************************************************
  // Preamble order and block position

  task automatic start_subframe(input byte kind);
    if ((kind == "Y") == cur_right)
      report_fault($sformatf("Preamble %c breaks the left/right order at %0t", kind, $time));
    cur_right = (kind == "Y");
    if (!cur_right)
    begin
      frame_idx = (frame_idx + 1) % spdif_pkg::BLOCK_FRAMES;
      if (block_known && ((frame_idx == 0) != (kind == "Z")))
        report_fault($sformatf("Preamble %c in frame %0d of the block", kind, frame_idx));
      if (kind == "Z")
      begin
        frame_idx   = 0;
        block_known = 1'b1;
        z_count++;
      end
    end
    in_data = 1'b1;
    pos     = 0;
    bit_idx = 0;
  endtask

  // **********************************************************
  // Slot contents

  task automatic end_subframe();
    logic [AUDIO_BITS-1:0] audio;
    logic                  lenient;
    audio   = bits[AUDIO_BITS-1:0];
    lenient = (grace > 0);
    subframes++;
    if (grace > 0)
      grace--;
    if (^bits !== 1'b0)
      report_fault($sformatf("CHECK FAILED spdif_o parity: slot %h is odd", bits));
    if (bits[26:24] !== 3'b000)
      report_fault($sformatf("CHECK FAILED spdif_o vuc: got %h expected 0", bits[26:24]));
    // New sample has arrived, the old one is no longer acceptable
    if (audio === cur_exp)
      grace = 0;
    else if (!(lenient && (audio === prev_exp)))
      report_fault($sformatf("CHECK FAILED spdif_o audio: got %h expected %h", audio, cur_exp));
    if (cur_right && (audio !== left_audio))
      report_fault($sformatf("CHECK FAILED spdif_o right audio: got %h expected %h",
                             audio, left_audio));
    if (!cur_right)
      left_audio = audio;
    in_data = 1'b0;
    pos     = 0;
  endtask

  // **********************************************************
  // Line decoding

  task automatic hunt(input logic s);
    byte kind;
    win  = {s, win[16:1]};
    kind = classify_preamble(win[16:1], win[0]);
    if (kind != 0)
    begin
      if (!started)
        report_fault("Preamble seen before any sample was sent");
      if (!ever_locked && (kind != "Z"))
        report_fault($sformatf("First preamble is %c instead of Z", kind));
      locked      = 1'b1;
      ever_locked = 1'b1;
      last_level  = win[16];
      cur_right   = (kind != "Y");
      start_subframe(kind);
    end
  endtask

  task automatic take_preamble(input logic s);
    byte kind;
    pre_buf[pos] = s;
    pos++;
    if (pos == spdif_pkg::PREAMBLE_CLKS)
    begin
      kind = classify_preamble(pre_buf, last_level);
      if (kind == 0)
        lose_lock($sformatf("Coding error: %b is no preamble", pre_buf), s);
      else
      begin
        last_level = pre_buf[15];
        start_subframe(kind);
      end
    end
  endtask

  // Level must flip at the boundary and hold for each half-cell
  task automatic take_cell(input logic s);
    cell_buf[pos] = s;
    pos++;
    if (pos == spdif_pkg::CELL_CLKS)
    begin
      if ((cell_buf[0] === last_level) || (cell_buf[1] !== cell_buf[0]) ||
          (cell_buf[3] !== cell_buf[2]))
        lose_lock($sformatf("Coding error: cell %b after level %b", cell_buf, last_level), s);
      else
      begin
        bits[bit_idx] = cell_buf[1] ^ cell_buf[2];
        last_level    = cell_buf[3];
        pos           = 0;
        bit_idx++;
        if (bit_idx == spdif_pkg::SUBFRAME_BITS)
          end_subframe();
      end
    end
  endtask

  always @(posedge exp_changed_i)
  begin
    prev_exp <= cur_exp;
    cur_exp  <= expected_sample_i;
    changes  <= changes + 1;
  end

  always @(posedge spdif_clk_i)
  begin : decode
    logic s;
    s = spdif_i;
    // A frame in progress may finish with the old sample
    if (changes != changes_seen)
    begin
      changes_seen = changes;
      started      = 1'b1;
      grace        = locked ? 3 : 2;
    end
    if (armed_i)
    begin
      if (!started && (s !== 1'b0) && !idle_fault)
      begin
        idle_fault = 1'b1;
        report_fault($sformatf("spdif_o left its low idle level before any sample at %0t",
                               $time));
      end
      if (!locked)
        hunt(s);
      else if (!in_data)
        take_preamble(s);
      else
        take_cell(s);
    end
  end

  // End-of-run totals
  task automatic check_totals(input int min_subframes);
    if (z_count < 2)
      report_fault($sformatf("Only %0d Z preambles seen, at least 2 expected", z_count));
    if (subframes < min_subframes)
      report_fault($sformatf("Only %0d subframes decoded, at least %0d expected",
                             subframes, min_subframes));
  endtask

endmodule

// File: verif/spdif_tb.sv
`timescale 1ns/100ps
// **********************************************************
// Testbench for the mono S/PDIF transmitter: plays a table
// of samples while the monitor decodes the line
// **********************************************************

module spdif_tb;

  localparam int ROWS        = 8;
  localparam int HOLD_FRAMES = 50;
  // Two subframes of preamble plus 28 cells
  localparam int FRAME_CLKS  = 2 * (spdif_pkg::PREAMBLE_CLKS +
                                    spdif_pkg::SUBFRAME_BITS * spdif_pkg::CELL_CLKS);
  // Table length in sys cycles with 20% margin
  localparam int TIMEOUT_CYCLES = ROWS * HOLD_FRAMES * FRAME_CLKS * 88 / 20 * 12 / 10;

  logic        sys_clk   = 1'b0;
  logic        spdif_clk = 1'b0;
  logic        srst;
  logic [23:0] sample;
  logic        sample_valid;
  logic        spdif;
  logic [23:0] expected_sample;
  logic        exp_changed;
  logic        armed;
  int          mon_errors;
  int          mon_subframes;
  int          sys_cycles = 0;
  int          row;
  int unsigned seed_value;

  // Stimulus table with one sample and its hold time in frames per row
  logic [23:0] stim_sample [ROWS];
  int          stim_hold   [ROWS];

  // 50 MHz system clock
  initial
  begin
    forever #10 sys_clk = ~sys_clk;
  end

  // 88 ns line clock near 11.2896 MHz
  initial
  begin
    forever #44 spdif_clk = ~spdif_clk;
  end

  spdif_tx_top #(
    .DATA_WIDTH (24)
  ) uut (
    .sys_clk_i      (sys_clk),
    .srst_i         (srst),
    .spdif_clk_i    (spdif_clk),
    .sample_i       (sample),
    .sample_valid_i (sample_valid),
    .spdif_o        (spdif)
  );

  spdif_monitor mon (
    .spdif_clk_i       (spdif_clk),
    .armed_i           (armed),
    .spdif_i           (spdif),
    .expected_sample_i (expected_sample),
    .exp_changed_i     (exp_changed),
    .errors_o          (mon_errors),
    .subframes_o       (mon_subframes)
  );

  // **********************************************************
  // Stimulus

  initial
  begin
    seed_value = 32'haa71_9563;
    seed_value = $urandom(seed_value);
    stim_sample[0] = 24'h000000;
    stim_sample[1] = 24'hffffff;
    stim_sample[2] = 24'h000001;
    stim_sample[3] = 24'haaaaaa;
    stim_sample[4] = 24'h555555;
    stim_sample[5] = 24'($urandom);
    stim_sample[6] = 24'($urandom);
    stim_sample[7] = 24'h800000;
    for (row = 0; row < ROWS; row++)
      stim_hold[row] = HOLD_FRAMES;

    srst            <= 1'b1;
    sample          <= '0;
    sample_valid    <= 1'b0;
    expected_sample <= '0;
    exp_changed     <= 1'b0;
    armed           <= 1'b0;
    repeat (10) @(posedge sys_clk);
    srst <= 1'b0;
    // Reset pulse needs a few line clocks to cross
    repeat (20) @(posedge spdif_clk);
    armed <= 1'b1;
    // Line stays low and quiet until the first sample
    repeat (40) @(posedge spdif_clk);

    for (row = 0; row < ROWS; row++)
    begin
      @(posedge sys_clk);
      expected_sample <= stim_sample[row];
      exp_changed     <= 1'b1;
      @(posedge sys_clk);
      exp_changed  <= 1'b0;
      sample       <= stim_sample[row];
      sample_valid <= 1'b1;
      @(posedge sys_clk);
      sample_valid <= 1'b0;
      repeat (stim_hold[row] * FRAME_CLKS) @(posedge spdif_clk);
    end

    mon.check_totals(ROWS * HOLD_FRAMES * 2 - 2);
    // Monitor has finished its last decode by the falling edge
    @(negedge spdif_clk);
    $display("Closing report: %0d errors, %0d subframes decoded", mon_errors, mon_subframes);
    if (mon_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // **********************************************************
  // Timeout

  initial
  begin
    while (sys_cycles < TIMEOUT_CYCLES)
    begin
      @(posedge sys_clk);
      sys_cycles++;
    end
    $display("Run timed out after %0d sys clock cycles with %0d errors", sys_cycles, mon_errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
source/spdif_pkg.sv
source/spdif_strobe_cdc.sv
source/spdif_subframe_builder.sv
source/spdif_transmitter.sv
source/spdif_tx_top.sv
verif/spdif_monitor.sv
verif/spdif_tb.sv
